// ==== all.f ====
rtl/tpu_pkg.sv
rtl/pe.sv
rtl/pe_array.sv
rtl/skew_feeder.sv
rtl/tpu_ctrl.sv
rtl/tpu_top.sv
testbench/tpu_assertions.sv
testbench/tb_tpu.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_tpu -f all.f
	@out="$$(./obj_dir/Vtb_tpu)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== testbench/tb_tpu.sv ====
`timescale 1ns/10ps

module tb_tpu;

    localparam int ARRAY_DIM = 4;
    localparam int DATA_W    = tpu_pkg::DATA_W;
    localparam int ACC_W     = tpu_pkg::ACC_W;
    localparam int WORD_W    = ARRAY_DIM * DATA_W;
    localparam int ROW_W     = ARRAY_DIM * ACC_W;
    localparam int ROW_BITS  = $clog2(ARRAY_DIM);
    localparam int MEM_DEPTH = 256;
    localparam int TIMEOUT   = 1000;

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    logic [tpu_pkg::DIM_W-1:0] k_len;
    logic [tpu_pkg::DIM_W-1:0] m_len;
    logic [tpu_pkg::DIM_W-1:0] n_len;
    logic                      busy;
    logic [tpu_pkg::IDX_W-1:0] a_index;
    logic [WORD_W-1:0]         a_data;
    logic [tpu_pkg::IDX_W-1:0] b_index;
    logic [WORD_W-1:0]         b_data;
    logic                      c_wr_en;
    logic [tpu_pkg::IDX_W-1:0] c_index;
    logic [ROW_W-1:0]          c_data;

    // Memory models
    logic [WORD_W-1:0] a_mem [MEM_DEPTH];
    logic [WORD_W-1:0] b_mem [MEM_DEPTH];
    logic [ROW_W-1:0]  c_mem [ARRAY_DIM];
    int                c_job [ARRAY_DIM];
    int                write_count;
    int                bad_writes;

    int seed;
    int errors;
    int tests_run;
    int tests_failed;
    int job_id;
    int write_base;
    bit timed_out;

    tpu_top #(
        .ARRAY_DIM (ARRAY_DIM)
    ) i_tpu_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .k_len    (k_len),
        .m_len    (m_len),
        .n_len    (n_len),
        .busy     (busy),
        .a_index  (a_index),
        .a_data   (a_data),
        .b_index  (b_index),
        .b_data   (b_data),
        .c_wr_en  (c_wr_en),
        .c_index  (c_index),
        .c_data   (c_data)
    );

    bind tpu_ctrl tpu_assertions u_assertions (
        .clk      (clk),
        .rst_n    (rst_n),
        .state    (state),
        .in_valid (in_valid),
        .busy     (busy),
        .c_wr_en  (c_wr_en),
        .c_index  (c_index),
        .m_lanes  (m_lanes)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Combinational reads
    assign a_data = a_mem[a_index[7:0]];
    assign b_data = b_mem[b_index[7:0]];

    // C capture, each row tagged with the job that wrote it
    always @(posedge clk) begin
        if (!rst_n) begin
            write_count <= 0;
            bad_writes  <= 0;
            for (int r = 0; r < ARRAY_DIM; r++) begin
                c_mem[r] <= '0;
                c_job[r] <= -1;
            end
        end else if (c_wr_en) begin
            write_count <= write_count + 1;
            if (int'(c_index) < ARRAY_DIM) begin
                c_mem[c_index[ROW_BITS-1:0]] <= c_data;
                c_job[c_index[ROW_BITS-1:0]] <= job_id;
            end else begin
                bad_writes <= bad_writes + 1;
            end
        end
    end

    // --------------------------------------------------
    // Stimulus helpers and reference model
    // --------------------------------------------------
    task automatic fill_pattern();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            a_mem[i] = {ARRAY_DIM{8'(i)}};
            b_mem[i] = {ARRAY_DIM{8'(i ^ 8'hA5)}};
        end
    endtask

    task automatic fill_random(input int k);
        for (int t = 0; t < k; t++) begin
            a_mem[t] = WORD_W'($random(seed));
            b_mem[t] = WORD_W'($random(seed));
        end
    endtask

    task automatic fill_const(input int k, input logic [DATA_W-1:0] val);
        for (int t = 0; t < k; t++) begin
            a_mem[t] = {ARRAY_DIM{val}};
            b_mem[t] = {ARRAY_DIM{val}};
        end
    endtask

    // Row i of A is byte i of each A word, column j of B is byte j of each B word
    function automatic logic [ACC_W-1:0] expected_c(input int i, input int j, input int k,
                                                    input int m, input int n);
        logic [ACC_W-1:0] sum;
        sum = '0;
        if (i >= m || j >= n) begin
            return '0;
        end
        for (int t = 0; t < k; t++) begin
            sum = sum + ACC_W'(a_mem[t][(ARRAY_DIM-1-i)*DATA_W +: DATA_W])
                      * ACC_W'(b_mem[t][(ARRAY_DIM-1-j)*DATA_W +: DATA_W]);
        end
        return sum;
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [ACC_W-1:0] exp_val,
                                   input logic [ACC_W-1:0] act_val);
        $display("FAILED %s %s expected %0d actual %0d", name, what, exp_val, act_val);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // Start one job, then follow busy until the FSM is idle again
    task automatic run_job(input string name, input int k, input int m, input int n,
                           input bit extra_pulse, output bit ok);
        int cycles;
        int busy_cycles;
        int expected_len;
        ok           = 1'b0;
        cycles       = 0;
        busy_cycles  = 0;
        expected_len = k + 2 * (ARRAY_DIM - 1) + 1 + m + 1;
        job_id++;
        write_base = write_count;
        @(posedge clk);
        in_valid <= 1'b1;
        k_len    <= tpu_pkg::DIM_W'(k);
        m_len    <= tpu_pkg::DIM_W'(m);
        n_len    <= tpu_pkg::DIM_W'(n);
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        while (!busy && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!busy) begin
            $display("%s: busy never rose after in_valid", name);
            errors++;
            timed_out = 1'b1;
            return;
        end
        while (busy && busy_cycles < TIMEOUT) begin
            busy_cycles++;
            @(posedge clk);
            // Start request while busy, must be ignored
            in_valid <= extra_pulse && (busy_cycles == 3);
            @(negedge clk);
        end
        if (busy) begin
            $display("%s: busy still high after %0d cycles", name, TIMEOUT);
            errors++;
            timed_out = 1'b1;
            return;
        end
        if (busy_cycles != expected_len) begin
            report_mismatch(name, "busy cycles", expected_len, busy_cycles);
        end
        ok = 1'b1;
    endtask

    task automatic check_result(input string name, input int k, input int m, input int n);
        logic [ACC_W-1:0] exp_val;
        logic [ACC_W-1:0] act_val;
        string            what;
        if (write_count - write_base != m) begin
            report_mismatch(name, "C write count", m, write_count - write_base);
        end
        if (bad_writes != 0) begin
            $display("%s: C written at an index beyond the array", name);
            errors++;
        end
        for (int r = 0; r < ARRAY_DIM; r++) begin
            if (r >= m) begin
                if (c_job[r] == job_id) begin
                    $display("%s: row %0d written although M is %0d", name, r, m);
                    errors++;
                end
            end else if (c_job[r] != job_id) begin
                $display("%s: row %0d was never written", name, r);
                errors++;
            end else begin
                for (int c = 0; c < ARRAY_DIM; c++) begin
                    exp_val = expected_c(r, c, k, m, n);
                    act_val = c_mem[r][(ARRAY_DIM-1-c)*ACC_W +: ACC_W];
                    if (act_val != exp_val) begin
                        what = $sformatf("C[%0d][%0d]", r, c);
                        report_mismatch(name, what, exp_val, act_val);
                    end
                end
            end
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset();
        int err_before;
        err_before = errors;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (busy !== 1'b0) begin
                report_mismatch("reset", "busy", 0, ACC_W'(busy));
            end
            if (c_wr_en !== 1'b0) begin
                report_mismatch("reset", "c_wr_en", 0, ACC_W'(c_wr_en));
            end
        end
        if (write_count != 0) begin
            report_mismatch("reset", "C write count", 0, write_count);
        end
        finish_test("reset", err_before);
    endtask

    task automatic test_full_job();
        int err_before;
        bit ok;
        err_before = errors;
        fill_random(4);
        run_job("full_4x4", 4, 4, 4, 1'b0, ok);
        if (ok) begin
            check_result("full_4x4", 4, 4, 4);
        end
        finish_test("full_4x4", err_before);
    endtask

    task automatic test_masking();
        int    err_before;
        bit    ok;
        string what;
        err_before = errors;
        fill_random(5);
        run_job("mask_m2_n3", 5, 2, 3, 1'b0, ok);
        if (ok) begin
            check_result("mask_m2_n3", 5, 2, 3);
            // Column 3 sits in the low 32 bits of a row
            for (int r = 0; r < 2; r++) begin
                if (c_mem[r][ACC_W-1:0] != '0) begin
                    what = $sformatf("C[%0d][3]", r);
                    report_mismatch("mask_m2_n3", what, 0, c_mem[r][ACC_W-1:0]);
                end
            end
        end
        finish_test("mask_m2_n3", err_before);
    endtask

    task automatic test_extremes();
        int err_before;
        bit ok;
        err_before = errors;
        fill_random(1);
        run_job("k1_random", 1, 4, 4, 1'b0, ok);
        if (ok) begin
            check_result("k1_random", 1, 4, 4);
        end
        fill_const(16, 8'hFF);
        run_job("k16_max", 16, 4, 4, 1'b0, ok);
        if (ok) begin
            check_result("k16_max", 16, 4, 4);
            if (c_mem[ARRAY_DIM-1][ACC_W-1:0] != ACC_W'(16 * 255 * 255)) begin
                report_mismatch("k16_max", "C[3][3]", ACC_W'(16 * 255 * 255),
                                c_mem[ARRAY_DIM-1][ACC_W-1:0]);
            end
        end
        finish_test("extremes", err_before);
    endtask

    task automatic test_back_to_back();
        int err_before;
        bit ok;
        err_before = errors;
        fill_random(3);
        run_job("first_job", 3, 4, 4, 1'b0, ok);
        if (ok) begin
            check_result("first_job", 3, 4, 4);
            fill_random(6);
            run_job("second_job", 6, 3, 4, 1'b1, ok);
        end
        if (ok) begin
            check_result("second_job", 6, 3, 4);
            // The ignored request must not start a job of its own
            for (int i = 0; i < 6; i++) begin
                @(negedge clk);
                if (busy !== 1'b0) begin
                    report_mismatch("second_job", "busy after job", 0, ACC_W'(busy));
                end
            end
            if (write_count - write_base != 3) begin
                report_mismatch("second_job", "C write count", 3, write_count - write_base);
            end
        end
        finish_test("back_to_back", err_before);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        seed         = 27917;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        job_id       = 0;
        write_base   = 0;
        timed_out    = 1'b0;
        rst_n    <= 1'b0;
        in_valid <= 1'b0;
        k_len    <= '0;
        m_len    <= '0;
        n_len    <= '0;
        fill_pattern();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        if (!timed_out) begin
            test_full_job();
        end
        if (!timed_out) begin
            test_masking();
        end
        if (!timed_out) begin
            test_extremes();
        end
        if (!timed_out) begin
            test_back_to_back();
        end

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== testbench/tpu_assertions.sv ====
`timescale 1ns/10ps

module tpu_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input tpu_pkg::tpu_state_t       state,
    input logic                      in_valid,
    input logic                      busy,
    input logic                      c_wr_en,
    input logic [tpu_pkg::IDX_W-1:0] c_index,
    input logic [tpu_pkg::DIM_W-1:0] m_lanes
);

    // Row writes belong to the write phase and stay below M
    a_wr_in_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        c_wr_en |-> (state == tpu_pkg::ST_WRITE) && (c_index < m_lanes)
    ) else $error("c_wr_en high outside ST_WRITE or at a row beyond M");

    // Accepted start raises busy on the next edge
    a_busy_start: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!busy && in_valid) |=> busy
    ) else $error("busy did not rise after an accepted start");

    // busy only drops once the flush is done
    a_busy_release: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> ($past(state) == tpu_pkg::ST_FLUSH)
    ) else $error("busy fell without a preceding ST_FLUSH");

    // Last row write leads straight into the flush
    a_write_to_flush: assert property (
        @(posedge clk) disable iff (!rst_n)
        (c_wr_en && (c_index == m_lanes - 1'b1)) |=> (state == tpu_pkg::ST_FLUSH)
    ) else $error("last C row write not followed by ST_FLUSH");

endmodule

// ==== rtl/tpu_top.sv ====
`timescale 1ns/10ps

module tpu_top #(
    parameter int ARRAY_DIM = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // Job control
    input  logic                                 in_valid,
    input  logic [tpu_pkg::DIM_W-1:0]            k_len,
    input  logic [tpu_pkg::DIM_W-1:0]            m_len,
    input  logic [tpu_pkg::DIM_W-1:0]            n_len,
    output logic                                 busy,

    // A memory, one column of A per word
    output logic [tpu_pkg::IDX_W-1:0]            a_index,
    input  logic [ARRAY_DIM*tpu_pkg::DATA_W-1:0] a_data,

    // B memory, one row of B per word
    output logic [tpu_pkg::IDX_W-1:0]            b_index,
    input  logic [ARRAY_DIM*tpu_pkg::DATA_W-1:0] b_data,

    // C memory, one row of C per word
    output logic                                 c_wr_en,
    output logic [tpu_pkg::IDX_W-1:0]            c_index,
    output logic [ARRAY_DIM*tpu_pkg::ACC_W-1:0]  c_data
);

    logic [tpu_pkg::IDX_W-1:0]            mem_index;
    logic                                 feed_en;
    logic [tpu_pkg::DIM_W-1:0]            m_lanes;
    logic [tpu_pkg::DIM_W-1:0]            n_lanes;
    logic                                 clear;
    logic [tpu_pkg::IDX_W-1:0]            row_sel;
    logic [ARRAY_DIM*tpu_pkg::DATA_W-1:0] west_edge;
    logic [ARRAY_DIM*tpu_pkg::DATA_W-1:0] north_edge;
    logic [ARRAY_DIM*tpu_pkg::ACC_W-1:0]  row_data;

    // --------------------------------------------------
    // Controller
    // --------------------------------------------------
    tpu_ctrl #(
        .ARRAY_DIM (ARRAY_DIM)
    ) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .k_len     (k_len),
        .m_len     (m_len),
        .n_len     (n_len),
        .busy      (busy),
        .mem_index (mem_index),
        .feed_en   (feed_en),
        .m_lanes   (m_lanes),
        .n_lanes   (n_lanes),
        .clear     (clear),
        .c_wr_en   (c_wr_en),
        .c_index   (c_index),
        .row_sel   (row_sel)
    );

    // Both operand streams step with the same k
    assign a_index = mem_index;
    assign b_index = mem_index;

    // --------------------------------------------------
    // Operand skew, A on the west edge, B on the north
    // --------------------------------------------------
    skew_feeder #(
        .ARRAY_DIM (ARRAY_DIM)
    ) u_feed_a (
        .clk        (clk),
        .rst_n      (rst_n),
        .feed_en    (feed_en),
        .lane_count (m_lanes),
        .mem_word   (a_data),
        .edge_out   (west_edge)
    );

    skew_feeder #(
        .ARRAY_DIM (ARRAY_DIM)
    ) u_feed_b (
        .clk        (clk),
        .rst_n      (rst_n),
        .feed_en    (feed_en),
        .lane_count (n_lanes),
        .mem_word   (b_data),
        .edge_out   (north_edge)
    );

    // --------------------------------------------------
    // Systolic array
    // --------------------------------------------------
    pe_array #(
        .ARRAY_DIM (ARRAY_DIM)
    ) u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .west_edge  (west_edge),
        .north_edge (north_edge),
        .row_sel    (row_sel),
        .row_data   (row_data)
    );

    assign c_data = row_data;

endmodule

// ==== rtl/tpu_ctrl.sv ====
`timescale 1ns/10ps

module tpu_ctrl #(
    parameter int ARRAY_DIM = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic [tpu_pkg::DIM_W-1:0] k_len,
    input  logic [tpu_pkg::DIM_W-1:0] m_len,
    input  logic [tpu_pkg::DIM_W-1:0] n_len,
    output logic                      busy,
    output logic [tpu_pkg::IDX_W-1:0] mem_index,
    output logic                      feed_en,
    output logic [tpu_pkg::DIM_W-1:0] m_lanes,
    output logic [tpu_pkg::DIM_W-1:0] n_lanes,
    output logic                      clear,
    output logic                      c_wr_en,
    output logic [tpu_pkg::IDX_W-1:0] c_index,
    output logic [tpu_pkg::IDX_W-1:0] row_sel
);

    // Drain covers the skew on both edges plus the last accumulate
    localparam int DRAIN_W = $clog2(2 * ARRAY_DIM);
    localparam logic [DRAIN_W-1:0] DRAIN_LAST = DRAIN_W'(2 * ARRAY_DIM - 2);

    tpu_pkg::tpu_state_t state, state_next;

    logic [tpu_pkg::DIM_W-1:0] k_q;
    logic [tpu_pkg::DIM_W-1:0] m_q;
    logic [tpu_pkg::DIM_W-1:0] n_q;
    logic [tpu_pkg::IDX_W-1:0] k_cnt;
    logic [DRAIN_W-1:0]        drain_cnt;
    logic [tpu_pkg::IDX_W-1:0] row_cnt;
    logic                      start;
    logic                      drain_done;
    logic                      rows_done;

    assign start      = (state == tpu_pkg::ST_IDLE) && in_valid;
    assign feed_en    = (state == tpu_pkg::ST_CALC) && (k_cnt < k_q);
    assign drain_done = (state == tpu_pkg::ST_CALC) && !feed_en && (drain_cnt == DRAIN_LAST);
    assign rows_done  = (row_cnt == m_q - 1'b1);

    // --------------------------------------------------
    // Job parameters
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            k_q <= '0;
            m_q <= '0;
            n_q <= '0;
        end else if (start) begin
            k_q <= k_len;
            m_q <= m_len;
            n_q <= n_len;
        end
    end

    // --------------------------------------------------
    // Counters
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            k_cnt     <= '0;
            drain_cnt <= '0;
            row_cnt   <= '0;
        end else if (start) begin
            k_cnt     <= '0;
            drain_cnt <= '0;
            row_cnt   <= '0;
        end else begin
            if (feed_en) begin
                k_cnt <= k_cnt + 1'b1;
            end
            // Zeros flow in while the last wavefront crosses the grid
            if (state == tpu_pkg::ST_CALC && !feed_en) begin
                drain_cnt <= drain_cnt + 1'b1;
            end
            if (state == tpu_pkg::ST_WRITE) begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= tpu_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            tpu_pkg::ST_IDLE:  if (start) state_next = tpu_pkg::ST_CALC;
            tpu_pkg::ST_CALC:  if (drain_done) state_next = tpu_pkg::ST_WRITE;
            tpu_pkg::ST_WRITE: if (rows_done) state_next = tpu_pkg::ST_FLUSH;
            default:           state_next = tpu_pkg::ST_IDLE;
        endcase
    end

    // Outputs
    assign busy      = (state != tpu_pkg::ST_IDLE);
    assign mem_index = k_cnt;
    assign m_lanes   = m_q;
    assign n_lanes   = n_q;
    assign clear     = (state == tpu_pkg::ST_FLUSH);
    assign c_wr_en   = (state == tpu_pkg::ST_WRITE);
    assign c_index   = row_cnt;
    assign row_sel   = row_cnt;

endmodule

// ==== rtl/skew_feeder.sv ====
`timescale 1ns/10ps

module skew_feeder #(
    parameter int ARRAY_DIM = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 feed_en,
    input  logic [tpu_pkg::DIM_W-1:0]            lane_count,
    input  logic [ARRAY_DIM*tpu_pkg::DATA_W-1:0] mem_word,
    output logic [ARRAY_DIM*tpu_pkg::DATA_W-1:0] edge_out
);

    // Lane i sits at the same byte position in mem_word and edge_out,
    // lane 0 in the top byte
    for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_lane
        localparam int LSB = (ARRAY_DIM - 1 - i) * tpu_pkg::DATA_W;

        logic                       lane_on;
        logic [tpu_pkg::DATA_W-1:0] lane_word;
        // Staircase: lane i has i+1 stages
        logic [tpu_pkg::DATA_W-1:0] pipe [0:i];

        // Lanes past M (or N) and idle cycles carry zeros
        assign lane_on   = feed_en && (int'(lane_count) > i);
        assign lane_word = lane_on ? mem_word[LSB +: tpu_pkg::DATA_W] : '0;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int s = 0; s <= i; s++) begin
                    pipe[s] <= '0;
                end
            end else begin
                pipe[0] <= lane_word;
                for (int s = 1; s <= i; s++) begin
                    pipe[s] <= pipe[s-1];
                end
            end
        end

        assign edge_out[LSB +: tpu_pkg::DATA_W] = pipe[i];
    end

endmodule

// ==== rtl/pe_array.sv ====
`timescale 1ns/10ps

module pe_array #(
    parameter int ARRAY_DIM = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 clear,
    input  logic [ARRAY_DIM*tpu_pkg::DATA_W-1:0] west_edge,
    input  logic [ARRAY_DIM*tpu_pkg::DATA_W-1:0] north_edge,
    input  logic [tpu_pkg::IDX_W-1:0]            row_sel,
    output logic [ARRAY_DIM*tpu_pkg::ACC_W-1:0]  row_data
);

    // h_link[r][c] enters cell (r,c) from the west, v_link[r][c] from the north.
    // The extra column/row holds the outputs of the east and south border cells.
    logic [tpu_pkg::DATA_W-1:0] h_link   [ARRAY_DIM][ARRAY_DIM+1];
    logic [tpu_pkg::DATA_W-1:0] v_link   [ARRAY_DIM+1][ARRAY_DIM];
    logic [tpu_pkg::ACC_W-1:0]  acc_grid [ARRAY_DIM][ARRAY_DIM];

    // --------------------------------------------------
    // Edge inputs, lane 0 in the top byte
    // --------------------------------------------------
    for (genvar l = 0; l < ARRAY_DIM; l++) begin : g_edge
        assign h_link[l][0] = west_edge[(ARRAY_DIM-1-l)*tpu_pkg::DATA_W +: tpu_pkg::DATA_W];
        assign v_link[0][l] = north_edge[(ARRAY_DIM-1-l)*tpu_pkg::DATA_W +: tpu_pkg::DATA_W];
    end

    // --------------------------------------------------
    // Cell grid
    // --------------------------------------------------
    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
            pe u_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .clear     (clear),
                .north_in  (v_link[r][c]),
                .west_in   (h_link[r][c]),
                .south_out (v_link[r+1][c]),
                .east_out  (h_link[r][c+1]),
                .acc       (acc_grid[r][c])
            );
        end
    end

    // --------------------------------------------------
    // Output row select, column 0 on top
    // --------------------------------------------------
    always_comb begin
        row_data = '0;
        for (int r = 0; r < ARRAY_DIM; r++) begin
            if (int'(row_sel) == r) begin
                for (int c = 0; c < ARRAY_DIM; c++) begin
                    row_data[(ARRAY_DIM-1-c)*tpu_pkg::ACC_W +: tpu_pkg::ACC_W] = acc_grid[r][c];
                end
            end
        end
    end

endmodule

// ==== rtl/pe.sv ====
`timescale 1ns/10ps

module pe (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       clear,
    input  logic [tpu_pkg::DATA_W-1:0] north_in,
    input  logic [tpu_pkg::DATA_W-1:0] west_in,
    output logic [tpu_pkg::DATA_W-1:0] south_out,
    output logic [tpu_pkg::DATA_W-1:0] east_out,
    output logic [tpu_pkg::ACC_W-1:0]  acc
);

    localparam int PAD_W = tpu_pkg::ACC_W - tpu_pkg::DATA_W;

    logic [tpu_pkg::ACC_W-1:0] product;

    // Unsigned 8x8 product, widened to the accumulator
    assign product = {{PAD_W{1'b0}}, north_in} * {{PAD_W{1'b0}}, west_in};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else begin
            acc <= acc + product;
        end
    end

    // Operands move one hop per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            south_out <= '0;
            east_out  <= '0;
        end else begin
            south_out <= north_in;
            east_out  <= west_in;
        end
    end

endmodule

// ==== rtl/tpu_pkg.sv ====
package tpu_pkg;

    // --------------------------------------------------
    // Datapath widths
    // --------------------------------------------------
    localparam int DATA_W = 8;
    localparam int ACC_W  = 32;
    localparam int IDX_W  = 16;
    localparam int DIM_W  = 16;

    // --------------------------------------------------
    // Controller states
    // --------------------------------------------------
    typedef enum logic [1:0] {
        ST_IDLE  = 2'b00,
        ST_CALC  = 2'b01,
        ST_WRITE = 2'b10,
        ST_FLUSH = 2'b11
    } tpu_state_t;

endpackage
